// File: verilog/cachePkg.sv
`default_nettype none

package cachePkg;

	// ********************************************************************
	// widths.
	// ********************************************************************

	localparam int ADDRESS_WIDTH = 16;
	localparam int DATA_WIDTH = 32;
	localparam int OFFSET_WIDTH = 2;
	localparam int INDEX_WIDTH = 4;
	localparam int TAG_WIDTH = ADDRESS_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

	// ********************************************************************
	// states and commands.
	// ********************************************************************

	typedef enum logic {
		INVALID = 1'b0,
		VALID = 1'b1
	} stateT;

	typedef enum logic {
		CPU_READ = 1'b0,
		CPU_WRITE = 1'b1
	} cpuCommandT;

	typedef enum logic {
		BUS_READ = 1'b0,
		BUS_WRITE = 1'b1
	} busCommandT;

	// events seen by the coherence rule.
	typedef enum logic [2:0] {
		CPU_READ_HIT = 3'd0,
		CPU_READ_FILL = 3'd1,
		CPU_WRITE_UPDATE = 3'd2,
		SNOOP_WRITE = 3'd3,
		NONE = 3'd4
	} protocolEventT;

	// ********************************************************************
	// addresses and requests.
	// ********************************************************************

	typedef struct packed {
		logic [TAG_WIDTH-1:0] tag;
		logic [INDEX_WIDTH-1:0] index;
		logic [OFFSET_WIDTH-1:0] offset;
	} addressFieldsT;

	// bus and memory see the raw word, the cache decodes the fields.
	typedef union packed {
		logic [ADDRESS_WIDTH-1:0] raw;
		addressFieldsT fields;
	} cacheAddressT;

	typedef struct packed {
		cpuCommandT command;
		cacheAddressT address;
		logic [DATA_WIDTH-1:0] data;
	} cpuRequestT;

	typedef struct packed {
		busCommandT command;
		cacheAddressT address;
		logic [DATA_WIDTH-1:0] data;
	} busRequestT;

endpackage : cachePkg

`default_nettype wire

// File: verilog/writeThroughInvalidate.sv
`default_nettype none

module writeThroughInvalidate (
	input wire cachePkg::protocolEventT protocolEvent,
	input wire cachePkg::stateT currentState,
	output cachePkg::stateT nextState
);
	import cachePkg::*;

	// two-state table of the write-through invalidate protocol.
	always_comb begin
		case (protocolEvent)
			CPU_READ_HIT: begin
				nextState = currentState;
			end
			CPU_READ_FILL: begin
				// a fetched word is a clean copy of memory.
				nextState = VALID;
			end
			CPU_WRITE_UPDATE: begin
				// memory is written too, so the copy stays as it was.
				nextState = currentState;
			end
			SNOOP_WRITE: begin
				// another node wrote memory.
				nextState = INVALID;
			end
			NONE: begin
				nextState = currentState;
			end
			default: begin
				nextState = currentState;
			end
		endcase
	end

endmodule : writeThroughInvalidate

`default_nettype wire

// File: verilog/setAssociativeCacheUnit.sv
`default_nettype none

module setAssociativeCacheUnit #(
	parameter int SET_ASSOCIATIVITY = 2
) (
	input wire logic clock,
	input wire logic arstN,
	input wire logic lookupStrobe,
	input wire cachePkg::cacheAddressT lookupAddress,
	output logic hit,
	output logic [cachePkg::DATA_WIDTH-1:0] hitData,
	input wire logic fillStrobe,
	input wire logic updateStrobe,
	input wire logic [cachePkg::DATA_WIDTH-1:0] updateData,
	input wire logic snoopStrobe,
	input wire cachePkg::cacheAddressT snoopAddress
);
	import cachePkg::*;

	localparam int SETS = 2 ** INDEX_WIDTH;
	localparam int WAY_WIDTH = (SET_ASSOCIATIVITY > 1) ? $clog2(SET_ASSOCIATIVITY) : 1;

	logic [TAG_WIDTH-1:0] tagArray [SET_ASSOCIATIVITY][SETS];
	logic [DATA_WIDTH-1:0] dataArray [SET_ASSOCIATIVITY][SETS];
	stateT stateArray [SET_ASSOCIATIVITY][SETS];
	logic [WAY_WIDTH-1:0] roundRobin [SETS];

	cacheAddressT lastAddress;
	logic [WAY_WIDTH-1:0] hitWay;
	logic [INDEX_WIDTH-1:0] lastIndex;
	logic [INDEX_WIDTH-1:0] snoopIndex;

	logic lookupHit;
	logic [WAY_WIDTH-1:0] lookupWay;
	logic victimFree;
	logic [WAY_WIDTH-1:0] victimWay;
	logic [WAY_WIDTH-1:0] nextPointer;
	logic snoopHit;
	logic [WAY_WIDTH-1:0] snoopWay;
	logic [WAY_WIDTH-1:0] cpuWay;

	protocolEventT cpuEvent;
	protocolEventT snoopEvent;
	stateT cpuNextState;
	stateT snoopNextState;

	assign lastIndex = lastAddress.fields.index;
	assign snoopIndex = snoopAddress.fields.index;

	// ********************************************************************
	// tag compare for lookups and snoops, victim choice for fills.
	// ********************************************************************

	always_comb begin
		lookupHit = 1'b0;
		lookupWay = '0;
		snoopHit = 1'b0;
		snoopWay = '0;
		victimFree = 1'b0;
		victimWay = roundRobin[lastIndex];
		// walked downwards so the lowest way wins.
		for (int w = SET_ASSOCIATIVITY - 1; w >= 0; w--) begin
			if (stateArray[w][lookupAddress.fields.index] == VALID &&
					tagArray[w][lookupAddress.fields.index] == lookupAddress.fields.tag) begin
				lookupHit = 1'b1;
				lookupWay = WAY_WIDTH'(w);
			end
			if (stateArray[w][snoopIndex] == VALID &&
					tagArray[w][snoopIndex] == snoopAddress.fields.tag) begin
				snoopHit = 1'b1;
				snoopWay = WAY_WIDTH'(w);
			end
			if (stateArray[w][lastIndex] == INVALID) begin
				victimFree = 1'b1;
				victimWay = WAY_WIDTH'(w);
			end
		end
	end

	assign nextPointer = (roundRobin[lastIndex] == WAY_WIDTH'(SET_ASSOCIATIVITY - 1)) ?
		'0 : roundRobin[lastIndex] + 1'b1;

	always_comb begin
		if (fillStrobe) begin
			cpuEvent = CPU_READ_FILL;
		end else if (updateStrobe && hit) begin
			cpuEvent = CPU_WRITE_UPDATE;
		end else begin
			cpuEvent = NONE;
		end
	end

	assign cpuWay = fillStrobe ? victimWay : hitWay;
	assign snoopEvent = (snoopStrobe && snoopHit) ? SNOOP_WRITE : NONE;

	writeThroughInvalidate cpuProtocol (
		.protocolEvent(cpuEvent),
		.currentState(stateArray[cpuWay][lastIndex]),
		.nextState(cpuNextState)
	);

	writeThroughInvalidate snoopProtocol (
		.protocolEvent(snoopEvent),
		.currentState(stateArray[snoopWay][snoopIndex]),
		.nextState(snoopNextState)
	);

	// ********************************************************************
	// storage.
	// ********************************************************************

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			hit <= 1'b0;
			for (int w = 0; w < SET_ASSOCIATIVITY; w++) begin
				for (int s = 0; s < SETS; s++) begin
					stateArray[w][s] <= INVALID;
				end
			end
			for (int s = 0; s < SETS; s++) begin
				roundRobin[s] <= '0;
			end
		end else begin
			if (lookupStrobe) begin
				hit <= lookupHit;
			end
			if (cpuEvent != NONE) begin
				stateArray[cpuWay][lastIndex] <= cpuNextState;
			end
			// later write, so the snoop wins on the same way.
			if (snoopEvent != NONE) begin
				stateArray[snoopWay][snoopIndex] <= snoopNextState;
			end
			if (fillStrobe && !victimFree) begin
				roundRobin[lastIndex] <= nextPointer;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (lookupStrobe) begin
			lastAddress <= lookupAddress;
			hitWay <= lookupWay;
			hitData <= dataArray[lookupWay][lookupAddress.fields.index];
		end
		if (fillStrobe) begin
			tagArray[victimWay][lastIndex] <= lastAddress.fields.tag;
			dataArray[victimWay][lastIndex] <= updateData;
		end else if (updateStrobe && hit) begin
			dataArray[hitWay][lastIndex] <= updateData;
		end
	end

endmodule : setAssociativeCacheUnit

`default_nettype wire

// File: verilog/cpuController.sv
`default_nettype none

module cpuController (
	input wire logic clock,
	input wire logic arstN,
	input wire logic cpuStrobe,
	input wire cachePkg::cpuRequestT cpuRequest,
	output logic cpuReady,
	output logic cpuDone,
	output logic [cachePkg::DATA_WIDTH-1:0] cpuReadData,
	output logic busStrobe,
	output cachePkg::busRequestT busRequest,
	input wire logic busDone,
	input wire logic [cachePkg::DATA_WIDTH-1:0] busReadData,
	output logic lookupStrobe,
	output cachePkg::cacheAddressT lookupAddress,
	output logic fillStrobe,
	output logic updateStrobe,
	output logic [cachePkg::DATA_WIDTH-1:0] updateData,
	input wire logic hit,
	input wire logic [cachePkg::DATA_WIDTH-1:0] hitData,
	input wire logic snoopStrobe,
	input wire cachePkg::cacheAddressT snoopAddress
);
	import cachePkg::*;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		DECIDE,
		BUS,
		RESPOND
	} controllerStateT;

	controllerStateT state;
	controllerStateT nextState;

	cpuRequestT request;
	logic requestHit;
	logic cancelFill;
	logic [DATA_WIDTH-1:0] responseData;

	cacheAddressT pendingAddress;
	logic snoopMatch;
	logic isRead;

	// ********************************************************************
	// snoop watch on the pending address.
	// ********************************************************************

	assign pendingAddress = (state == IDLE) ? cpuRequest.address : request.address;

	// the offset only selects bytes, so it is left out of the match.
	assign snoopMatch = snoopStrobe &&
		snoopAddress.fields.tag == pendingAddress.fields.tag &&
		snoopAddress.fields.index == pendingAddress.fields.index;

	assign isRead = (request.command == CPU_READ);

	// ********************************************************************
	// sequencer.
	// ********************************************************************

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (cpuStrobe) begin
					nextState = LOOKUP;
				end
			end
			LOOKUP: begin
				nextState = DECIDE;
			end
			DECIDE: begin
				if (isRead && requestHit) begin
					nextState = IDLE;
				end else begin
					nextState = BUS;
				end
			end
			BUS: begin
				// memory latency has no bound here.
				if (busDone) begin
					nextState = RESPOND;
				end
			end
			RESPOND: begin
				nextState = IDLE;
			end
			default: begin
				nextState = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
			requestHit <= 1'b0;
			cancelFill <= 1'b0;
		end else begin
			state <= nextState;
			if (state == LOOKUP) begin
				requestHit <= hit;
			end
			if (state == IDLE) begin
				cancelFill <= cpuStrobe && snoopMatch;
			end else if (snoopMatch) begin
				cancelFill <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state == IDLE && cpuStrobe) begin
			request <= cpuRequest;
		end
		if (state == LOOKUP) begin
			responseData <= hitData;
		end else if (state == BUS && busDone) begin
			responseData <= busReadData;
		end
	end

	// ********************************************************************
	// outputs.
	// ********************************************************************

	assign cpuReady = (state == IDLE);
	assign cpuDone = (state == DECIDE && isRead && requestHit) || (state == RESPOND);
	assign cpuReadData = responseData;

	assign lookupStrobe = (state == IDLE) && cpuStrobe;
	assign lookupAddress = cpuRequest.address;

	// writes always go through, reads only on a miss.
	assign busStrobe = (state == DECIDE) && !(isRead && requestHit);
	assign busRequest.command = isRead ? BUS_READ : BUS_WRITE;
	assign busRequest.address = request.address;
	assign busRequest.data = request.data;

	assign updateStrobe = (state == DECIDE) && !isRead && requestHit;
	// a snoop in the fill cycle also drops the fill.
	assign fillStrobe = (state == RESPOND) && isRead && !requestHit && !cancelFill && !snoopMatch;
	assign updateData = isRead ? responseData : request.data;

endmodule : cpuController

`default_nettype wire

// File: verilog/snoopyCacheNode.sv
`default_nettype none

module snoopyCacheNode #(
	parameter int SET_ASSOCIATIVITY = 2
) (
	input wire logic clock,
	input wire logic arstN,
	input wire logic cpuStrobe,
	input wire cachePkg::cpuRequestT cpuRequest,
	output logic cpuReady,
	output logic cpuDone,
	output logic [cachePkg::DATA_WIDTH-1:0] cpuReadData,
	output logic busStrobe,
	output cachePkg::busRequestT busRequest,
	input wire logic busDone,
	input wire logic [cachePkg::DATA_WIDTH-1:0] busReadData,
	input wire logic snoopStrobe,
	input wire cachePkg::cacheAddressT snoopAddress
);
	import cachePkg::*;

	// controller to cache unit.
	logic lookupStrobe;
	cacheAddressT lookupAddress;
	logic fillStrobe;
	logic updateStrobe;
	logic [DATA_WIDTH-1:0] updateData;
	logic hit;
	logic [DATA_WIDTH-1:0] hitData;

	cpuController cpuController_inst (
		.clock(clock),
		.arstN(arstN),
		.cpuStrobe(cpuStrobe),
		.cpuRequest(cpuRequest),
		.cpuReady(cpuReady),
		.cpuDone(cpuDone),
		.cpuReadData(cpuReadData),
		.busStrobe(busStrobe),
		.busRequest(busRequest),
		.busDone(busDone),
		.busReadData(busReadData),
		.lookupStrobe(lookupStrobe),
		.lookupAddress(lookupAddress),
		.fillStrobe(fillStrobe),
		.updateStrobe(updateStrobe),
		.updateData(updateData),
		.hit(hit),
		.hitData(hitData),
		.snoopStrobe(snoopStrobe),
		.snoopAddress(snoopAddress)
	);

	setAssociativeCacheUnit #(
		.SET_ASSOCIATIVITY(SET_ASSOCIATIVITY)
	) setAssociativeCacheUnit_inst (
		.clock(clock),
		.arstN(arstN),
		.lookupStrobe(lookupStrobe),
		.lookupAddress(lookupAddress),
		.hit(hit),
		.hitData(hitData),
		.fillStrobe(fillStrobe),
		.updateStrobe(updateStrobe),
		.updateData(updateData),
		.snoopStrobe(snoopStrobe),
		.snoopAddress(snoopAddress)
	);

endmodule : snoopyCacheNode

`default_nettype wire

// File: dv/snoopyCacheNodeTb.sv
`default_nettype none

module snoopyCacheNodeTb;
	import cachePkg::*;

	localparam int WAYS = 2;
	localparam int SETS = 2 ** INDEX_WIDTH;
	localparam int WORD_WIDTH = ADDRESS_WIDTH - OFFSET_WIDTH;
	localparam int RESET_CYCLES = 16;
	localparam int DIRECTED_REQUESTS = 30;
	localparam int RANDOM_OPS = 300;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40 * (DIRECTED_REQUESTS + RANDOM_OPS);

	typedef struct packed {
		logic isRead;
		logic busUse;
		busRequestT busRequest;
		logic [DATA_WIDTH-1:0] readData;
	} expectT;

	logic clock;
	logic arstN;
	logic cpuStrobe;
	cpuRequestT cpuRequest;
	logic cpuReady;
	logic cpuDone;
	logic [DATA_WIDTH-1:0] cpuReadData;
	logic busStrobe;
	busRequestT busRequest;
	logic busDone;
	logic [DATA_WIDTH-1:0] busReadData;
	logic snoopStrobe;
	cacheAddressT snoopAddress;

	// memory behind the bus, and the reference model of memory and cache.
	logic [DATA_WIDTH-1:0] memory [2 ** WORD_WIDTH];
	logic [DATA_WIDTH-1:0] refMemory [2 ** WORD_WIDTH];
	logic [TAG_WIDTH-1:0] refTag [WAYS][SETS];
	logic refValid [WAYS][SETS];
	logic [DATA_WIDTH-1:0] refData [WAYS][SETS];
	int refPointer [SETS];

	logic [31:0] lfsr = 32'h268d_9a4d;
	expectT expectQueue [$];
	expectT inFlight;
	bit busSeen;
	int cycleCount;
	int strobeCycle;
	int doneCount;
	int checkCount;
	int errorCount;
	int testCount;

	snoopyCacheNode #(
		.SET_ASSOCIATIVITY(WAYS)
	) snoopyCacheNode_inst (
		.clock(clock),
		.arstN(arstN),
		.cpuStrobe(cpuStrobe),
		.cpuRequest(cpuRequest),
		.cpuReady(cpuReady),
		.cpuDone(cpuDone),
		.cpuReadData(cpuReadData),
		.busStrobe(busStrobe),
		.busRequest(busRequest),
		.busDone(busDone),
		.busReadData(busReadData),
		.snoopStrobe(snoopStrobe),
		.snoopAddress(snoopAddress)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
	end

	// ********************************************************************
	// random numbers and memory contents.
	// ********************************************************************

	// taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsrStep(logic [31:0] current);
		return {current[30:0], current[31] ^ current[21] ^ current[1] ^ current[0]};
	endfunction

	function automatic logic [31:0] randomBits(int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsrStep(lfsr);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	function automatic logic [DATA_WIDTH-1:0] memoryPattern(logic [WORD_WIDTH-1:0] word);
		return {2'b10, word, ~word, 2'b01};
	endfunction

	// ********************************************************************
	// reference model.
	// ********************************************************************

	function automatic expectT predictRequest(cpuRequestT request, bit snoopInMiss);
		expectT result;
		int way;
		int victim;
		logic [INDEX_WIDTH-1:0] index;
		logic [TAG_WIDTH-1:0] tag;
		logic [WORD_WIDTH-1:0] word;
		index = request.address.fields.index;
		tag = request.address.fields.tag;
		word = request.address.raw[ADDRESS_WIDTH-1:OFFSET_WIDTH];
		way = -1;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (refValid[w][index] && refTag[w][index] == tag) begin
				way = w;
			end
		end
		result.isRead = (request.command == CPU_READ);
		result.busUse = !result.isRead || way < 0;
		result.busRequest.command = result.isRead ? BUS_READ : BUS_WRITE;
		result.busRequest.address = request.address;
		result.busRequest.data = request.data;
		result.readData = '0;
		if (result.isRead && way >= 0) begin
			result.readData = refData[way][index];
		end else if (result.isRead) begin
			result.readData = refMemory[word];
			// a snoop on the pending address drops the fill.
			if (!snoopInMiss) begin
				victim = -1;
				for (int w = WAYS - 1; w >= 0; w--) begin
					if (!refValid[w][index]) begin
						victim = w;
					end
				end
				if (victim < 0) begin
					victim = refPointer[index];
					refPointer[index] = (victim == WAYS - 1) ? 0 : victim + 1;
				end
				refTag[victim][index] = tag;
				refValid[victim][index] = 1'b1;
				refData[victim][index] = refMemory[word];
			end
		end else begin
			refMemory[word] = request.data;
			if (way >= 0) begin
				refData[way][index] = request.data;
			end
		end
		return result;
	endfunction

	function automatic void applySnoop(cacheAddressT address);
		for (int w = 0; w < WAYS; w++) begin
			if (refValid[w][address.fields.index] &&
					refTag[w][address.fields.index] == address.fields.tag) begin
				refValid[w][address.fields.index] = 1'b0;
			end
		end
	endfunction

	// ********************************************************************
	// compare tasks.
	// ********************************************************************

	task automatic compareData(string name, logic [DATA_WIDTH-1:0] actual,
			logic [DATA_WIDTH-1:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL %0t %s actual %h expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic compareBusRequest(string name, busRequestT actual, busRequestT expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL %0t %s actual cmd %0d addr %h data %h expected cmd %0d addr %h data %h",
				$time, name, actual.command, actual.address.raw, actual.data,
				expected.command, expected.address.raw, expected.data);
		end
	endtask

	task automatic compareBusUse(string name, bit actual, bit expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL %0t %s actual %0b expected %0b", $time, name, actual, expected);
		end
	endtask

	task automatic compareCycles(string name, int actual, int expected);
		checkCount++;
		if (actual != expected) begin
			errorCount++;
			$display("FAIL %0t %s actual %0d expected %0d", $time, name, actual, expected);
		end
	endtask

	// ********************************************************************
	// stimulus.
	// ********************************************************************

	task automatic runRequest(cpuCommandT command, logic [ADDRESS_WIDTH-1:0] address,
			logic [DATA_WIDTH-1:0] data, bit snoopInMiss);
		cpuRequestT request;
		int target;
		request.command = command;
		request.address.raw = address;
		request.data = data;
		do begin
			@(negedge clock);
		end while (!cpuReady);
		@(posedge clock);
		#1;
		cpuStrobe = 1'b1;
		cpuRequest = request;
		strobeCycle = cycleCount;
		target = doneCount + 1;
		expectQueue.push_back(predictRequest(request, snoopInMiss));
		@(posedge clock);
		#1;
		cpuStrobe = 1'b0;
		if (snoopInMiss) begin
			do begin
				@(negedge clock);
			end while (!busStrobe);
			@(posedge clock);
			#1;
			snoopStrobe = 1'b1;
			snoopAddress.raw = address;
			@(posedge clock);
			#1;
			snoopStrobe = 1'b0;
		end
		while (doneCount != target) begin
			@(posedge clock);
		end
	endtask

	// another node writes memory, this node sees the write on the bus.
	task automatic snoopWrite(logic [ADDRESS_WIDTH-1:0] address, logic [DATA_WIDTH-1:0] data);
		cacheAddressT snooped;
		snooped.raw = address;
		memory[snooped.raw[ADDRESS_WIDTH-1:OFFSET_WIDTH]] = data;
		refMemory[snooped.raw[ADDRESS_WIDTH-1:OFFSET_WIDTH]] = data;
		applySnoop(snooped);
		@(posedge clock);
		#1;
		snoopStrobe = 1'b1;
		snoopAddress = snooped;
		@(posedge clock);
		#1;
		snoopStrobe = 1'b0;
	endtask

	task automatic reportTest(string name, int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("test %0d %s: passed", testCount, name);
		end else begin
			$display("test %0d %s: failed with %0d mismatches", testCount, name,
				errorCount - errorsBefore);
		end
	endtask

	// ********************************************************************
	// memory responder, result checker and watchdog.
	// ********************************************************************

	initial begin
		busRequestT captured;
		int delay;
		logic [WORD_WIDTH-1:0] word;
		forever begin
			@(negedge clock);
			if (arstN && busStrobe) begin
				captured = busRequest;
				delay = 1 + int'(randomBits(3));
				repeat (delay) @(posedge clock);
				#1;
				compareBusRequest("busRequest held", busRequest, captured);
				word = captured.address.raw[ADDRESS_WIDTH-1:OFFSET_WIDTH];
				if (captured.command == BUS_WRITE) begin
					memory[word] = captured.data;
				end
				busReadData = memory[word];
				busDone = 1'b1;
				@(posedge clock);
				#1;
				busDone = 1'b0;
			end
		end
	end

	always @(negedge clock) begin
		if (arstN && busStrobe) begin
			if (expectQueue.size() == 0) begin
				errorCount++;
				$display("busStrobe at %0t while no request was in flight", $time);
			end else begin
				busSeen = 1'b1;
				compareBusRequest("busRequest", busRequest, expectQueue[0].busRequest);
			end
		end
		if (arstN && cpuDone) begin
			if (expectQueue.size() == 0) begin
				errorCount++;
				$display("cpuDone at %0t while no request was in flight", $time);
			end else begin
				inFlight = expectQueue.pop_front();
				compareBusUse("busStrobe seen", busSeen, inFlight.busUse);
				// the node stays busy until the cycle after cpuDone.
				compareBusUse("cpuReady at cpuDone", cpuReady, 1'b0);
				if (inFlight.isRead) begin
					compareData("cpuReadData", cpuReadData, inFlight.readData);
				end
				if (inFlight.isRead && !inFlight.busUse) begin
					compareCycles("read hit latency", cycleCount - strobeCycle, 2);
				end
				busSeen = 1'b0;
				doneCount++;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired after %0d cycles, %0d requests done", WATCHDOG_CYCLES,
			doneCount);
		$display("ERRORS FOUND");
		$finish;
	end

	// ********************************************************************
	// tests.
	// ********************************************************************

	initial begin
		int errorsBefore;
		cacheAddressT randomAddress;
		logic [1:0] choice;
		logic [DATA_WIDTH-1:0] randomData;
		arstN = 1'b0;
		cpuStrobe = 1'b0;
		cpuRequest = '0;
		busDone = 1'b0;
		busReadData = '0;
		snoopStrobe = 1'b0;
		snoopAddress = '0;
		for (int i = 0; i < 2 ** WORD_WIDTH; i++) begin
			memory[i] = memoryPattern(WORD_WIDTH'(i));
			refMemory[i] = memoryPattern(WORD_WIDTH'(i));
		end
		for (int s = 0; s < SETS; s++) begin
			refPointer[s] = 0;
			for (int w = 0; w < WAYS; w++) begin
				refValid[w][s] = 1'b0;
			end
		end
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		arstN = 1'b1;

		errorsBefore = errorCount;
		@(negedge clock);
		compareBusUse("cpuReady", cpuReady, 1'b1);
		compareBusUse("busStrobe", busStrobe, 1'b0);
		runRequest(CPU_READ, 16'h0100, 32'h0, 1'b0);
		reportTest("first read after reset", errorsBefore);

		errorsBefore = errorCount;
		runRequest(CPU_READ, 16'h0100, 32'h0, 1'b0);
		runRequest(CPU_READ, 16'h0102, 32'h0, 1'b0);
		reportTest("repeated read hits", errorsBefore);

		errorsBefore = errorCount;
		runRequest(CPU_WRITE, 16'h0100, 32'ha5a5_0f0f, 1'b0);
		runRequest(CPU_READ, 16'h0100, 32'h0, 1'b0);
		runRequest(CPU_WRITE, 16'h0240, 32'h1234_5678, 1'b0);
		runRequest(CPU_READ, 16'h0240, 32'h0, 1'b0);
		reportTest("write through", errorsBefore);

		errorsBefore = errorCount;
		runRequest(CPU_READ, 16'h0380, 32'h0, 1'b0);
		runRequest(CPU_READ, 16'h0380, 32'h0, 1'b0);
		snoopWrite(16'h0380, 32'h1357_9bdf);
		runRequest(CPU_READ, 16'h0380, 32'h0, 1'b0);
		runRequest(CPU_READ, 16'h0480, 32'h0, 1'b1);
		runRequest(CPU_READ, 16'h0480, 32'h0, 1'b0);
		runRequest(CPU_READ, 16'h0480, 32'h0, 1'b0);
		reportTest("snoop invalidate", errorsBefore);

		// three tags in set 9.
		errorsBefore = errorCount;
		runRequest(CPU_READ, 16'h1024, 32'h0, 1'b0);
		runRequest(CPU_READ, 16'h2024, 32'h0, 1'b0);
		runRequest(CPU_READ, 16'h3024, 32'h0, 1'b0);
		runRequest(CPU_READ, 16'h1024, 32'h0, 1'b0);
		runRequest(CPU_READ, 16'h2024, 32'h0, 1'b0);
		runRequest(CPU_READ, 16'h3024, 32'h0, 1'b0);
		runRequest(CPU_READ, 16'h3024, 32'h0, 1'b0);
		snoopWrite(16'h2024, 32'h2468_ace0);
		runRequest(CPU_READ, 16'h1024, 32'h0, 1'b0);
		runRequest(CPU_READ, 16'h2024, 32'h0, 1'b0);
		runRequest(CPU_READ, 16'h3024, 32'h0, 1'b0);
		reportTest("victim choice", errorsBefore);

		errorsBefore = errorCount;
		for (int i = 0; i < RANDOM_OPS; i++) begin
			choice = 2'(randomBits(2));
			randomAddress.raw = '0;
			randomAddress.fields.tag = TAG_WIDTH'(randomBits(2));
			randomAddress.fields.index = INDEX_WIDTH'(randomBits(2));
			randomAddress.fields.offset = OFFSET_WIDTH'(randomBits(2));
			randomData = randomBits(DATA_WIDTH);
			case (choice)
				2'd2: runRequest(CPU_WRITE, randomAddress.raw, randomData, 1'b0);
				2'd3: snoopWrite(randomAddress.raw, randomData);
				default: runRequest(CPU_READ, randomAddress.raw, randomData, 1'b0);
			endcase
		end
		reportTest("random reads, writes and snoops", errorsBefore);

		$display("tests %0d, checks %0d, mismatches %0d", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule : snoopyCacheNodeTb

`default_nettype wire

// File: filelist.f
verilog/cachePkg.sv
verilog/writeThroughInvalidate.sv
verilog/setAssociativeCacheUnit.sv
verilog/cpuController.sv
verilog/snoopyCacheNode.sv
dv/snoopyCacheNodeTb.sv

// File: Makefile
TOP := snoopyCacheNodeTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator output"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
